// File: hdl/mul_array.sv
//--------------------------------------------------------------------------
// 65x65 signed multiplier array
// ex1 registers four 33x33 partial products, ex2 registers their sum
//--------------------------------------------------------------------------
`timescale 1ns/1ps

module mul_array (
  input  logic           mult_clk,
  input  logic           cpurst_b,
  input  logic           mult_sel,
  input  logic           ex1_vld,
  input  logic           ex2_vld,
  input  mul_pkg::opnd_t op_a,
  input  mul_pkg::opnd_t op_b,
  output mul_pkg::prod_t prod
);

  import mul_pkg::*;

  opnd_t              a_q;
  opnd_t              b_q;
  // operand halves, high part signed, low part zero extended
  logic signed [32:0] a_hi;
  logic signed [32:0] a_lo;
  logic signed [32:0] b_hi;
  logic signed [32:0] b_lo;
  logic signed [65:0] pp_hh_q;
  logic signed [65:0] pp_hl_q;
  logic signed [65:0] pp_lh_q;
  logic signed [65:0] pp_ll_q;
  prod_t              sum;
  prod_t              prod_q;

  //------------------------------------------------------------------------
  // ex1 operands, loaded on issue
  //------------------------------------------------------------------------
  always_ff @(posedge mult_clk or negedge cpurst_b) begin
    if (!cpurst_b) begin
      a_q <= '0;
      b_q <= '0;
    end else if (mult_sel) begin
      a_q <= op_a;
      b_q <= op_b;
    end
  end

  assign a_hi = a_q[64:32];
  assign b_hi = b_q[64:32];
  assign a_lo = {1'b0, a_q[31:0]};
  assign b_lo = {1'b0, b_q[31:0]};

  //------------------------------------------------------------------------
  // ex1 partial products
  //------------------------------------------------------------------------
  always_ff @(posedge mult_clk or negedge cpurst_b) begin
    if (!cpurst_b) begin
      pp_hh_q <= '0;
      pp_hl_q <= '0;
      pp_lh_q <= '0;
      pp_ll_q <= '0;
    end else if (ex1_vld) begin
      pp_hh_q <= a_hi * b_hi;
      pp_hl_q <= a_hi * b_lo;
      pp_lh_q <= a_lo * b_hi;
      // always positive
      pp_ll_q <= a_lo * b_lo;
    end
  end

  //------------------------------------------------------------------------
  // ex2 sum, modulo 2^130
  //------------------------------------------------------------------------
  // the full signed product fits 130 bits, so bits shifted out are dropped
  assign sum = {pp_hh_q, 64'b0}
             + {{32{pp_hl_q[65]}}, pp_hl_q, 32'b0}
             + {{32{pp_lh_q[65]}}, pp_lh_q, 32'b0}
             + {64'b0, pp_ll_q};

  always_ff @(posedge mult_clk or negedge cpurst_b) begin
    if (!cpurst_b) begin
      prod_q <= '0;
    end else if (ex2_vld) begin
      prod_q <= sum;
    end
  end

  // stable through ex3
  assign prod = prod_q;

endmodule

// File: hdl/mul_decode.sv
//--------------------------------------------------------------------------
// multiply decode
// matches the eight multiply opcodes, widens both sources to 65 bits
// and picks the write-back result form
//--------------------------------------------------------------------------
`timescale 1ns/1ps

module mul_decode (
  input  mul_pkg::inst_t inst,
  input  mul_pkg::data_t src0,
  input  mul_pkg::data_t src1,
  output mul_pkg::opnd_t op_a,
  output mul_pkg::opnd_t op_b,
  output mul_pkg::rsel_t rsel
);

  import mul_pkg::*;

  opc_t opc;
  logic hit;
  logic word;
  logic sgn;

  // widen one source
  // word forms rebuild bits 63..32, unsigned forms keep bit 64 clear
  function automatic opnd_t widen(input data_t src, input logic is_word,
                                  input logic is_sgn);
    logic [31:0] upper;
    logic        top;
    upper = is_word ? {32{is_sgn & src[31]}} : src[63:32];
    top   = is_sgn & (is_word ? src[31] : src[63]);
    return {top, upper, src[31:0]};
  endfunction

  assign opc = inst[31:15];

  //------------------------------------------------------------------------
  // opcode match
  //------------------------------------------------------------------------
  always_comb begin
    hit  = 1'b1;
    word = 1'b0;
    sgn  = 1'b1;
    rsel = rsel_lo64;
    case (opc)
      opc_mul_w: begin
        word = 1'b1;
        rsel = rsel_lo32;
      end
      opc_mulh_w: begin
        word = 1'b1;
        rsel = rsel_hi32;
      end
      opc_mulh_wu: begin
        word = 1'b1;
        sgn  = 1'b0;
        rsel = rsel_hi32;
      end
      // full width low half
      opc_mul_d: rsel = rsel_lo64;
      opc_mulh_d: rsel = rsel_hi64;
      opc_mulh_du: begin
        sgn  = 1'b0;
        rsel = rsel_hi64;
      end
      // 32x32 to 64, whole product kept
      opc_mulw_d_w: word = 1'b1;
      opc_mulw_d_wu: begin
        word = 1'b1;
        sgn  = 1'b0;
      end
      default: hit = 1'b0;
    endcase
  end

  // unknown opcode gives zero operands
  assign op_a = hit ? widen(src0, word, sgn) : '0;
  assign op_b = hit ? widen(src1, word, sgn) : '0;

endmodule

// File: hdl/mul_pipe_ctrl.sv
//--------------------------------------------------------------------------
// multiply pipeline control
// ex1..ex4 valid chain with flush, destination tag and result-select
// sidebands, issue stall
//--------------------------------------------------------------------------
`timescale 1ns/1ps

module mul_pipe_ctrl (
  input  logic           mult_clk,
  input  logic           cpurst_b,
  input  logic           mult_sel,
  input  logic           flush,
  input  mul_pkg::preg_t dst_preg,
  input  mul_pkg::rsel_t rsel,
  output logic           ex1_vld,
  output logic           ex2_vld,
  output logic           ex3_vld,
  output logic           wb_vld,
  output mul_pkg::preg_t wb_preg,
  output mul_pkg::rsel_t ex4_rsel,
  output logic           issue_stall,
  output logic           no_op
);

  import mul_pkg::*;

  // index 0 is ex1, index 3 is ex4
  logic [3:0]        vld_q;
  logic [3:0]        load;
  preg_t [3:0]       preg_q;
  preg_t [3:0]       preg_d;
  rsel_t [3:0]       rsel_q;
  rsel_t [3:0]       rsel_d;

  //------------------------------------------------------------------------
  // valid chain
  //------------------------------------------------------------------------
  always_ff @(posedge mult_clk or negedge cpurst_b) begin
    if (!cpurst_b) begin
      vld_q <= '0;
    end else if (flush) begin
      // flush kills every stage at once
      vld_q <= '0;
    end else begin
      vld_q <= {vld_q[2:0], mult_sel};
    end
  end

  //------------------------------------------------------------------------
  // tag and select sidebands
  //------------------------------------------------------------------------
  // stage i loads from stage i-1, ex1 loads from the issue port
  assign load   = {vld_q[2:0], mult_sel};
  assign preg_d = {preg_q[2:0], dst_preg};
  assign rsel_d = {rsel_q[2:0], rsel};

  always_ff @(posedge mult_clk or negedge cpurst_b) begin
    if (!cpurst_b) begin
      preg_q <= '0;
      rsel_q <= '0;
    end else begin
      for (int i = 0; i < 4; i++) begin
        if (load[i]) begin
          preg_q[i] <= preg_d[i];
          rsel_q[i] <= rsel_d[i];
        end
      end
    end
  end

  // stage enables for the datapath
  assign ex1_vld  = vld_q[0];
  assign ex2_vld  = vld_q[1];
  assign ex3_vld  = vld_q[2];

  // write-back from ex4
  assign wb_vld   = vld_q[3];
  assign wb_preg  = preg_q[3];
  assign ex4_rsel = rsel_q[3];

  // any operation in flight holds off the issuer
  assign issue_stall = |vld_q;
  assign no_op       = ~issue_stall;

endmodule

// File: hdl/mul_pkg.sv
//--------------------------------------------------------------------------
// multiply unit shared definitions
// widths, vector types, opcode constants and result-select codes
//--------------------------------------------------------------------------
package mul_pkg;

  // widths
  localparam int data_w = 64;
  localparam int opnd_w = 65;
  localparam int prod_w = 130;
  localparam int rslt_w = 128;
  localparam int preg_w = 6;
  localparam int inst_w = 32;
  // major opcode field, inst[31:15]
  localparam int opc_w  = 17;

  // vector types
  typedef logic [data_w-1:0] data_t;
  typedef logic [opnd_w-1:0] opnd_t;
  typedef logic [prod_w-1:0] prod_t;
  typedef logic [rslt_w-1:0] rslt_t;
  typedef logic [preg_w-1:0] preg_t;
  typedef logic [inst_w-1:0] inst_t;
  typedef logic [opc_w-1:0]  opc_t;
  typedef logic [1:0]        rsel_t;

  //------------------------------------------------------------------------
  // opcodes
  //------------------------------------------------------------------------
  localparam opc_t opc_mul_w     = 17'h00038;
  localparam opc_t opc_mulh_w    = 17'h00039;
  localparam opc_t opc_mulh_wu   = 17'h0003a;
  localparam opc_t opc_mul_d     = 17'h0003b;
  localparam opc_t opc_mulh_d    = 17'h0003c;
  localparam opc_t opc_mulh_du   = 17'h0003d;
  localparam opc_t opc_mulw_d_w  = 17'h0003e;
  localparam opc_t opc_mulw_d_wu = 17'h0003f;

  //------------------------------------------------------------------------
  // result selects
  //------------------------------------------------------------------------
  // product[63:0]
  localparam rsel_t rsel_lo64 = 2'd0;
  // product[127:64]
  localparam rsel_t rsel_hi64 = 2'd1;
  // product[31:0], sign extended from bit 31
  localparam rsel_t rsel_lo32 = 2'd2;
  // product[63:32], sign extended from bit 63
  localparam rsel_t rsel_hi32 = 2'd3;

endpackage

// File: hdl/mul_result_sel.sv
//--------------------------------------------------------------------------
// multiply result selection
// ex4 product register and write-back data forms
//--------------------------------------------------------------------------
`timescale 1ns/1ps

module mul_result_sel (
  input  logic           mult_clk,
  input  logic           cpurst_b,
  input  logic           ex3_vld,
  input  mul_pkg::prod_t prod,
  input  mul_pkg::rsel_t ex4_rsel,
  output mul_pkg::data_t wb_data
);

  import mul_pkg::*;

  rslt_t rslt_q;

  // ex4 product, top two bits not needed by any form
  always_ff @(posedge mult_clk or negedge cpurst_b) begin
    if (!cpurst_b) begin
      rslt_q <= '0;
    end else if (ex3_vld) begin
      rslt_q <= prod[rslt_w-1:0];
    end
  end

  //------------------------------------------------------------------------
  // write-back data
  //------------------------------------------------------------------------
  always_comb begin
    case (ex4_rsel)
      rsel_lo64: wb_data = rslt_q[63:0];
      rsel_hi64: wb_data = rslt_q[127:64];
      // word results
      rsel_lo32: wb_data = {{32{rslt_q[31]}}, rslt_q[31:0]};
      rsel_hi32: wb_data = {{32{rslt_q[63]}}, rslt_q[63:32]};
      default:   wb_data = rslt_q[63:0];
    endcase
  end

endmodule

// File: hdl/mul_unit.sv
//--------------------------------------------------------------------------
// four-stage integer multiply unit
// decode, pipeline control, 65x65 array and result selection
//--------------------------------------------------------------------------
`timescale 1ns/1ps

module mul_unit (
  input  logic           mult_clk,
  input  logic           cpurst_b,
  input  logic           mult_sel,
  input  mul_pkg::inst_t inst,
  input  mul_pkg::data_t src0,
  input  mul_pkg::data_t src1,
  input  mul_pkg::preg_t dst_preg,
  input  logic           flush,
  output logic           issue_stall,
  output logic           no_op,
  output logic           wb_vld,
  output mul_pkg::preg_t wb_preg,
  output mul_pkg::data_t wb_data
);

  import mul_pkg::*;

  // decode to ex1
  opnd_t op_a;
  opnd_t op_b;
  rsel_t rsel;
  // stage enables
  logic  ex1_vld;
  logic  ex2_vld;
  logic  ex3_vld;
  rsel_t ex4_rsel;
  prod_t prod;

  mul_decode x_mul_decode (
    .inst (inst),
    .src0 (src0),
    .src1 (src1),
    .op_a (op_a),
    .op_b (op_b),
    .rsel (rsel)
  );

  mul_pipe_ctrl x_mul_pipe_ctrl (
    .mult_clk    (mult_clk),
    .cpurst_b    (cpurst_b),
    .mult_sel    (mult_sel),
    .flush       (flush),
    .dst_preg    (dst_preg),
    .rsel        (rsel),
    .ex1_vld     (ex1_vld),
    .ex2_vld     (ex2_vld),
    .ex3_vld     (ex3_vld),
    .wb_vld      (wb_vld),
    .wb_preg     (wb_preg),
    .ex4_rsel    (ex4_rsel),
    .issue_stall (issue_stall),
    .no_op       (no_op)
  );

  mul_array x_mul_array (
    .mult_clk (mult_clk),
    .cpurst_b (cpurst_b),
    .mult_sel (mult_sel),
    .ex1_vld  (ex1_vld),
    .ex2_vld  (ex2_vld),
    .op_a     (op_a),
    .op_b     (op_b),
    .prod     (prod)
  );

  mul_result_sel x_mul_result_sel (
    .mult_clk (mult_clk),
    .cpurst_b (cpurst_b),
    .ex3_vld  (ex3_vld),
    .prod     (prod),
    .ex4_rsel (ex4_rsel),
    .wb_data  (wb_data)
  );

endmodule

// File: mul_unit.f
hdl/mul_pkg.sv
hdl/mul_decode.sv
hdl/mul_array.sv
hdl/mul_pipe_ctrl.sv
hdl/mul_result_sel.sv
hdl/mul_unit.sv
verif/mul_unit_sva.sv
verif/mul_unit_tb.sv

// File: verif/mul_unit_sva.sv
//----------------------------------------------------------------------------
// multiply unit timing checks
// issue to write-back latency, stall rule and issue handshake
//----------------------------------------------------------------------------
`timescale 1ns/1ps

module mul_unit_sva (
  input logic mult_clk,
  input logic cpurst_b,
  input logic mult_sel,
  input logic flush,
  input logic wb_vld,
  input logic issue_stall
);

  // failures so far, summed into the final report
  int fail_cnt = 0;

  // unflushed issue writes back in n+4
  a_issue_to_wb: assert property (@(posedge mult_clk) disable iff (!cpurst_b)
    (mult_sel && !flush) ##1 (!flush) [*3] |=> wb_vld)
    else begin
      fail_cnt++;
      $error("wb_vld missing 4 cycles after issue");
    end

  // stall covers n+1..n+4 of an unflushed issue, then drops
  a_stall_window: assert property (@(posedge mult_clk)
    disable iff (!cpurst_b || flush)
    mult_sel |=> issue_stall [*4] ##1 !issue_stall)
    else begin
      fail_cnt++;
      $error("issue_stall not high for exactly 4 cycles after issue");
    end

  // issuer honours the stall
  a_sel_no_stall: assert property (@(posedge mult_clk) disable iff (!cpurst_b)
    mult_sel |-> !issue_stall)
    else begin
      fail_cnt++;
      $error("mult_sel high while issue_stall is high");
    end

  // no write-back without an issue 4 cycles earlier
  a_wb_has_issue: assert property (@(posedge mult_clk) disable iff (!cpurst_b)
    wb_vld |-> $past(mult_sel, 4))
    else begin
      fail_cnt++;
      $error("wb_vld without an issue 4 cycles earlier");
    end

endmodule

bind mul_unit mul_unit_sva u_sva (
  .mult_clk    (mult_clk),
  .cpurst_b    (cpurst_b),
  .mult_sel    (mult_sel),
  .flush       (flush),
  .wb_vld      (wb_vld),
  .issue_stall (issue_stall)
);

// File: verif/mul_unit_tb.sv
//----------------------------------------------------------------------------
// multiply unit testbench
// corner and random operands on all eight opcodes against a wide
// arithmetic model, plus stall, back-to-back and flush cases
//----------------------------------------------------------------------------
`timescale 1ns/1ps

module mul_unit_tb;

  import mul_pkg::*;

  localparam int wait_max = 20;

  logic        mult_clk;
  logic        cpurst_b;
  logic        mult_sel;
  inst_t       inst;
  data_t       src0;
  data_t       src1;
  preg_t       dst_preg;
  logic        flush;
  logic        issue_stall;
  logic        no_op;
  logic        wb_vld;
  preg_t       wb_preg;
  data_t       wb_data;

  logic [31:0] lfsr;
  int          errors;
  int          tests;
  int          failed_tests;
  int          test_err0;

  mul_unit UUT (.*);

  initial begin
    mult_clk = 1'b0;
    forever #20 mult_clk = ~mult_clk;
  end

  // galois step, taps 32 22 2 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
  endfunction

  // one step per bit taken
  task automatic rand_bits(input int n, output logic [63:0] v);
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr_step(lfsr);
      v[i] = lfsr[0];
    end
  endtask

  //--------------------------------------------------------------------------
  // reference model
  //--------------------------------------------------------------------------
  function automatic data_t expected_result(input opc_t opc, input data_t a,
                                            input data_t b);
    logic signed [127:0] ss;
    logic [127:0]        uu;
    logic signed [63:0]  sw;
    logic [63:0]         uw;
    ss = $signed(a) * $signed(b);
    uu = a * b;
    // word forms only see the low halves
    sw = $signed(a[31:0]) * $signed(b[31:0]);
    uw = a[31:0] * b[31:0];
    case (opc)
      opc_mul_w:     return {{32{uw[31]}}, uw[31:0]};
      opc_mulh_w:    return {{32{sw[63]}}, sw[63:32]};
      opc_mulh_wu:   return {{32{uw[63]}}, uw[63:32]};
      opc_mul_d:     return uu[63:0];
      opc_mulh_d:    return ss[127:64];
      opc_mulh_du:   return uu[127:64];
      opc_mulw_d_w:  return sw;
      opc_mulw_d_wu: return uw;
      default:       return '0;
    endcase
  endfunction

  task automatic check_val(input string name, input logic [63:0] got,
                           input logic [63:0] exp);
    assert (got === exp) else begin
      $display("** Error: %s = 0x%0h, expected 0x%0h", name, got, exp);
      errors++;
    end
  endtask

  //--------------------------------------------------------------------------
  // one operation, issue to write-back or flush
  //--------------------------------------------------------------------------
  task automatic do_op(input opc_t opc, input data_t a, input data_t b, input bit kill);
    logic [63:0] r;
    preg_t       tag;
    data_t       exp;
    int          cyc;
    bit          done;
    rand_bits(preg_w, r);
    tag = r[preg_w-1:0];
    exp = expected_result(opc, a, b);
    // idle, or the op in flight writes back now
    cyc = 0;
    while (issue_stall && !wb_vld && cyc < wait_max) begin
      @(negedge mult_clk);
      cyc++;
    end
    if (issue_stall && !wb_vld) begin
      $display("timeout: issue_stall stayed high for %0d cycles", wait_max);
      errors++;
    end
    rand_bits(15, r);
    @(posedge mult_clk);
    mult_sel <= 1'b1;
    inst     <= {opc, r[14:0]};
    src0     <= a;
    src1     <= b;
    dst_preg <= tag;
    // cycle n, also n+5 of the previous op
    @(negedge mult_clk);
    check_val("issue_stall", issue_stall, 0);
    check_val("no_op", no_op, 1);
    @(posedge mult_clk);
    mult_sel <= 1'b0;
    cyc  = 0;
    done = 0;
    while (!done) begin
      @(negedge mult_clk);
      cyc++;
      if (kill) begin
        // flushed at the end of n+2
        check_val("wb_vld", wb_vld, 0);
        check_val("issue_stall", issue_stall, cyc < 3);
        check_val("no_op", no_op, cyc >= 3);
        done = (cyc == 5);
      end else if (wb_vld) begin
        check_val("wb_vld cycle after issue", cyc, 4);
        check_val("issue_stall", issue_stall, 1);
        check_val("no_op", no_op, 0);
        check_val("wb_preg", wb_preg, tag);
        check_val("wb_data", wb_data, exp);
        done = 1;
      end else begin
        check_val("issue_stall", issue_stall, 1);
        check_val("no_op", no_op, 0);
        if (cyc == wait_max) begin
          $display("timeout: no write-back within %0d cycles of issue", wait_max);
          errors++;
          done = 1;
        end
      end
      if (!done) begin
        @(posedge mult_clk);
        flush <= kill && (cyc == 1);
      end
    end
  endtask

  // corners then random pairs for one opcode
  task automatic run_set(input opc_t opc);
    logic [63:0] r;
    data_t       a;
    data_t       b;
    do_op(opc, '1, '1, 0);
    do_op(opc, 64'h8000_0000_0000_0000, 64'h8000_0000_0000_0000, 0);
    do_op(opc, 64'h8000_0000_0000_0000, '1, 0);
    // garbage above bit 31
    rand_bits(32, r);
    do_op(opc, {r[31:0], 32'h8000_0000}, {~r[31:0], 32'h8000_0000}, 0);
    do_op(opc, {r[31:0], 32'hffff_ffff}, {r[31:0], 32'h7fff_ffff}, 0);
    for (int i = 0; i < 4; i++) begin
      rand_bits(64, a);
      rand_bits(64, b);
      do_op(opc, a, b, 0);
    end
  endtask

  task automatic end_test(input string name);
    tests++;
    if (errors != test_err0) begin
      failed_tests++;
    end
    $display("test %-14s %s", name, (errors == test_err0) ? "passed" : "failed");
    test_err0 = errors;
  endtask

  //--------------------------------------------------------------------------
  // test sequence
  //--------------------------------------------------------------------------
  initial begin
    data_t       a;
    data_t       b;
    logic [63:0] r;
    lfsr         = 32'd85843;
    errors       = 0;
    tests        = 0;
    failed_tests = 0;
    test_err0    = 0;
    cpurst_b     = 1'b0;
    mult_sel     = 1'b0;
    inst         = '0;
    src0         = '0;
    src1         = '0;
    dst_preg     = '0;
    flush        = 1'b0;
    repeat (3) @(posedge mult_clk);
    cpurst_b <= 1'b1;
    // idle before any issue
    @(negedge mult_clk);
    check_val("wb_vld", wb_vld, 0);
    check_val("issue_stall", issue_stall, 0);
    check_val("no_op", no_op, 1);
    end_test("reset");
    run_set(opc_mul_d);
    run_set(opc_mulh_d);
    run_set(opc_mulh_du);
    end_test("dword");
    run_set(opc_mul_w);
    run_set(opc_mulh_w);
    run_set(opc_mulh_wu);
    run_set(opc_mulw_d_w);
    run_set(opc_mulw_d_wu);
    end_test("word");
    // mixed opcodes, each issued as the stall drops
    for (int i = 0; i < 8; i++) begin
      rand_bits(3, r);
      rand_bits(64, a);
      rand_bits(64, b);
      do_op(opc_mul_w + r[2:0], a, b, 0);
    end
    end_test("back_to_back");
    // flush in n+2, then a clean op
    rand_bits(64, a);
    rand_bits(64, b);
    do_op(opc_mulh_d, a, b, 1);
    do_op(opc_mulh_du, a, b, 0);
    end_test("flush");
    repeat (2) @(negedge mult_clk);
    $display("tests %0d, failed %0d, data errors %0d, assertion failures %0d",
             tests, failed_tests, errors, UUT.u_sva.fail_cnt);
    if (errors == 0 && UUT.u_sva.fail_cnt == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

endmodule
